/* logic/bus_pkg.sv */
// APB request/response types and the per-channel register map, imported by the bus-side logic
package bus_pkg;

  // host bus widths
  localparam int ADDR_W = 8;
  localparam int DATA_W = 16;

  // paddr field positions
  localparam int IDX_LSB  = 2;
  localparam int CHAN_LSB = 5;

  // register index within a channel block
  typedef logic [2:0] reg_idx_t;
  // channel block select
  typedef logic [2:0] chan_sel_t;

  localparam reg_idx_t REG_CTRL     = 3'd0;
  localparam reg_idx_t REG_STEP_DIV = 3'd1;
  localparam reg_idx_t REG_PHASE    = 3'd2;
  localparam reg_idx_t REG_DUTY     = 3'd3;
  localparam reg_idx_t REG_TICKS    = 3'd4;
  // read only from here on
  localparam reg_idx_t REG_CUR_TICK = 3'd5;
  localparam reg_idx_t REG_STATUS   = 3'd6;
  // not mapped, always answers with an error
  localparam reg_idx_t REG_UNDEF    = 3'd7;

  typedef struct packed {
    logic [ADDR_W-1:0] paddr;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [DATA_W-1:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] prdata;
    logic              pready;
    logic              pslverr;
  } apb_rsp_t;

endpackage

/* logic/pin_pkg.sv */
// waveform pin channel types and sizes, shared by the register file and every channel slice
package pin_pkg;

  // number of waveform channels in the bank
  localparam int NUM_PINS = 4;

  // position and level width
  localparam int POS_W  = 8;
  // step divider width
  localparam int DIV_W  = 16;
  // period counter width
  localparam int TICK_W = 16;

  // codes 5 to 7 are rejected by the register file
  typedef enum logic [2:0] {
    WAVE_OFF    = 3'd0,
    WAVE_SQUARE = 3'd1,
    WAVE_SAW    = 3'd2,
    WAVE_TRI    = 3'd3,
    WAVE_PWM    = 3'd4
  } wave_t;

  // step_div of 0 acts as 1, ticks of 0 runs forever
  typedef struct packed {
    wave_t             wave;
    logic [DIV_W-1:0]  step_div;
    logic [POS_W-1:0]  phase;
    logic [POS_W-1:0]  duty;
    logic [TICK_W-1:0] ticks;
  } pin_cfg_t;

  typedef struct packed {
    logic              running;
    logic [TICK_W-1:0] cur_tick;
  } pin_status_t;

  typedef struct packed {
    logic [POS_W-1:0] level;
    logic             pin;
  } pin_out_t;

endpackage

/* logic/apb_regfile.sv */
// APB slave holding the configuration of all channels, issuing start/stop pulses and readback
`timescale 1ns/1ps

module apb_regfile (
  input  logic                          sys_clk,
  input  logic                          reset,
  input  bus_pkg::apb_req_t             req,
  output bus_pkg::apb_rsp_t             rsp,
  output pin_pkg::pin_cfg_t             cfg [pin_pkg::NUM_PINS],
  output logic [pin_pkg::NUM_PINS-1:0]  start,
  output logic [pin_pkg::NUM_PINS-1:0]  stop,
  input  pin_pkg::pin_status_t          status [pin_pkg::NUM_PINS]
);
  import bus_pkg::*;
  import pin_pkg::*;

  chan_sel_t         chan;
  reg_idx_t          idx;
  wave_t             code;
  logic              access;
  logic              chan_ok;
  logic              err;
  logic              wr_en;
  pin_cfg_t          rd_cfg;
  pin_status_t       rd_status;
  logic [DATA_W-1:0] rd_data;

  // address decode
  assign chan    = req.paddr[CHAN_LSB +: $bits(chan_sel_t)];
  assign idx     = req.paddr[IDX_LSB +: $bits(reg_idx_t)];
  assign code    = wave_t'(req.pwdata[$bits(wave_t)-1:0]);
  // access phase of a transfer
  assign access  = req.psel && req.penable;
  assign chan_ok = int'(chan) < NUM_PINS;

  // error cases checked before any write lands
  always_comb begin
    err = !chan_ok || (idx == REG_UNDEF);
    if (req.pwrite) begin
      // status registers are read only
      if (idx == REG_CUR_TICK || idx == REG_STATUS) begin
        err = 1'b1;
      end
      // illegal waveform codes
      if (idx == REG_CTRL && code > WAVE_PWM) begin
        err = 1'b1;
      end
    end
  end

  assign wr_en = access && req.pwrite && !err;

  // pick the addressed channel for readback
  always_comb begin
    rd_cfg    = cfg[0];
    rd_status = status[0];
    for (int i = 0; i < NUM_PINS; i++) begin
      if (int'(chan) == i) begin
        rd_cfg    = cfg[i];
        rd_status = status[i];
      end
    end
  end

  // readback mux with zero extension to the bus width
  always_comb begin
    case (idx)
      REG_CTRL:     rd_data = {{(DATA_W-$bits(wave_t)){1'b0}}, rd_cfg.wave};
      REG_STEP_DIV: rd_data = rd_cfg.step_div;
      REG_PHASE:    rd_data = {{(DATA_W-POS_W){1'b0}}, rd_cfg.phase};
      REG_DUTY:     rd_data = {{(DATA_W-POS_W){1'b0}}, rd_cfg.duty};
      REG_TICKS:    rd_data = rd_cfg.ticks;
      REG_CUR_TICK: rd_data = rd_status.cur_tick;
      REG_STATUS:   rd_data = {{(DATA_W-1){1'b0}}, rd_status.running};
      default:      rd_data = '0;
    endcase
  end

  // zero wait states and data only on a good read access
  always_comb begin
    rsp.pready  = 1'b1;
    rsp.pslverr = access && err;
    rsp.prdata  = (access && !req.pwrite && !err) ? rd_data : '0;
  end

  // config storage and one-cycle ctrl pulses
  always_ff @(posedge sys_clk) begin
    if (reset) begin
      for (int i = 0; i < NUM_PINS; i++) begin
        cfg[i] <= '0;
      end
      start <= '0;
      stop  <= '0;
    end else begin
      start <= '0;
      stop  <= '0;
      for (int i = 0; i < NUM_PINS; i++) begin
        if (wr_en && int'(chan) == i) begin
          case (idx)
            REG_CTRL: begin
              cfg[i].wave <= code;
              // nonzero code starts or restarts and off stops
              start[i] <= (code != WAVE_OFF);
              stop[i]  <= (code == WAVE_OFF);
            end
            REG_STEP_DIV: cfg[i].step_div <= req.pwdata;
            REG_PHASE:    cfg[i].phase    <= req.pwdata[POS_W-1:0];
            REG_DUTY:     cfg[i].duty     <= req.pwdata[POS_W-1:0];
            REG_TICKS:    cfg[i].ticks    <= req.pwdata;
            default:      cfg[i]          <= cfg[i];
          endcase
        end
      end
    end
  end

  // a ctrl pulse never lasts past one cycle
  a_pulse_one_cycle: assert property (
    @(posedge sys_clk) disable iff (reset) (start | stop) != '0 |=> (start | stop) == '0
  );

  // every access cycle follows a setup cycle
  a_setup_first: assert property (
    @(posedge sys_clk) disable iff (reset) access |-> $past(req.psel && !req.penable)
  );

endmodule

/* logic/channel_fsm.sv */
// per-channel run control: loads on start, counts completed periods, ends on limit or stop
`timescale 1ns/1ps

module channel_fsm (
  input  logic                       sys_clk,
  input  logic                       reset,
  input  logic                       start,
  input  logic                       stop,
  input  logic [pin_pkg::TICK_W-1:0] ticks,
  input  logic                       wrap,
  output pin_pkg::pin_status_t       status,
  output logic                       load
);
  import pin_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    LOAD,
    RUN
  } state_t;

  state_t            state;
  state_t            state_d;
  logic              stop_q;
  logic              last_wrap;
  logic [TICK_W-1:0] cur_tick;

  // wrap that brings the count to a nonzero limit
  assign last_wrap = wrap && (ticks != '0) && ((cur_tick + 1'b1) == ticks);

  always_comb begin
    state_d = state;
    case (state)
      IDLE: state_d = IDLE;
      // stop lands one cycle late, lined up with start through LOAD
      LOAD: state_d = stop_q ? IDLE : RUN;
      RUN: begin
        if (stop_q || last_wrap) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
    // start wins, also restarts a running channel
    if (start) begin
      state_d = LOAD;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (reset) begin
      state    <= IDLE;
      stop_q   <= 1'b0;
      cur_tick <= '0;
    end else begin
      state  <= state_d;
      stop_q <= stop;
      // count restarts on load, kept after a stop
      if (state == LOAD) begin
        cur_tick <= '0;
      end else if (state == RUN && wrap) begin
        cur_tick <= cur_tick + 1'b1;
      end
    end
  end

  assign load   = (state == LOAD);
  assign status = '{running: (state == RUN), cur_tick: cur_tick};

  // shaper only wraps while this channel runs
  a_wrap_in_run: assert property (
    @(posedge sys_clk) disable iff (reset) wrap |-> (state == RUN)
  );

endmodule

/* logic/step_timer.sv */
// per-channel step divider, one step pulse every step_div cycles while the channel runs
`timescale 1ns/1ps

module step_timer (
  input  logic                      sys_clk,
  input  logic                      reset,
  input  logic                      load,
  input  logic                      run,
  input  logic [pin_pkg::DIV_W-1:0] step_div,
  output logic                      step
);
  import pin_pkg::*;

  logic [DIV_W-1:0] cnt;
  logic [DIV_W-1:0] div_eff;

  // divider of zero behaves as one
  assign div_eff = (step_div == '0) ? DIV_W'(1) : step_div;

  // last cycle of the count
  assign step = run && (cnt == DIV_W'(1));

  always_ff @(posedge sys_clk) begin
    if (reset) begin
      cnt <= '0;
    end else if (load || step) begin
      // reload picks up a divider changed mid run
      cnt <= div_eff;
    end else if (run) begin
      cnt <= cnt - 1'b1;
    end
    // otherwise hold
  end

endmodule

/* logic/wave_shaper.sv */
// per-channel position register and waveform decode into the registered level and pin
`timescale 1ns/1ps

module wave_shaper (
  input  logic                      sys_clk,
  input  logic                      reset,
  input  logic                      load,
  input  logic                      step,
  input  logic                      run,
  input  pin_pkg::wave_t            wave,
  input  logic [pin_pkg::POS_W-1:0] phase,
  input  logic [pin_pkg::POS_W-1:0] duty,
  output logic                      wrap,
  output pin_pkg::pin_out_t         out
);
  import pin_pkg::*;

  logic [POS_W-1:0] pos;
  logic [POS_W-1:0] pos_d;
  logic [POS_W-1:0] tri_src;
  pin_out_t         shape;
  pin_out_t         out_q;

  // next position: phase on load, +1 per step, wraps mod 256
  always_comb begin
    if (load) begin
      pos_d = phase;
    end else if (step) begin
      pos_d = pos + 1'b1;
    end else begin
      pos_d = pos;
    end
  end

  // step from the top position back to zero
  assign wrap = run && step && (pos == '1);

  // decode on the next position so out_q lines up with pos
  always_comb begin
    // falling half mirrors, 255 - p
    tri_src = pos_d[POS_W-1] ? ~pos_d : pos_d;
    shape   = '0;
    case (wave)
      // full scale in the lower half
      WAVE_SQUARE: shape.level = {POS_W{~pos_d[POS_W-1]}};
      WAVE_SAW:    shape.level = pos_d;
      // doubled slope up then down
      WAVE_TRI:    shape.level = {tri_src[POS_W-2:0], 1'b0};
      // high while below duty
      WAVE_PWM:    shape.level = {POS_W{pos_d < duty}};
      default:     shape.level = '0;
    endcase
    // pin follows the msb of the level for every shape
    shape.pin = shape.level[POS_W-1];
  end

  always_ff @(posedge sys_clk) begin
    if (reset) begin
      pos   <= '0;
      out_q <= '0;
    end else begin
      pos   <= pos_d;
      out_q <= shape;
    end
  end

  // idle channel drives zero
  assign out = run ? out_q : '0;

endmodule

/* logic/pin_bank_top.sv */
// pin bank top level, APB register file feeding one run/step/shape slice per channel
`timescale 1ns/1ps

module pin_bank_top (
  input  logic              sys_clk,
  input  logic              reset,
  input  bus_pkg::apb_req_t req,
  output bus_pkg::apb_rsp_t rsp,
  output pin_pkg::pin_out_t pins [pin_pkg::NUM_PINS]
);
  import pin_pkg::*;

  pin_cfg_t            cfg [NUM_PINS];
  pin_status_t         status [NUM_PINS];
  logic [NUM_PINS-1:0] start;
  logic [NUM_PINS-1:0] stop;

  // shared register window
  apb_regfile u_regfile (
    .sys_clk (sys_clk),
    .reset   (reset),
    .req     (req),
    .rsp     (rsp),
    .cfg     (cfg),
    .start   (start),
    .stop    (stop),
    .status  (status)
  );

  // one slice per channel, run taken from its own status
  for (genvar i = 0; i < NUM_PINS; i++) begin : g_chan
    logic load;
    logic step;
    logic wrap;

    channel_fsm u_fsm (
      .sys_clk (sys_clk),
      .reset   (reset),
      .start   (start[i]),
      .stop    (stop[i]),
      .ticks   (cfg[i].ticks),
      .wrap    (wrap),
      .status  (status[i]),
      .load    (load)
    );

    step_timer u_timer (
      .sys_clk  (sys_clk),
      .reset    (reset),
      .load     (load),
      .run      (status[i].running),
      .step_div (cfg[i].step_div),
      .step     (step)
    );

    wave_shaper u_shaper (
      .sys_clk (sys_clk),
      .reset   (reset),
      .load    (load),
      .step    (step),
      .run     (status[i].running),
      .wave    (cfg[i].wave),
      .phase   (cfg[i].phase),
      .duty    (cfg[i].duty),
      .wrap    (wrap),
      .out     (pins[i])
    );
  end

endmodule

/* bench/bench_clock.sv */
// testbench clock and reset source for the pin bank, 40 ns period with a 16 cycle reset
`timescale 1ns/1ps

module bench_clock (
  output logic sys_clk,
  output logic reset
);

  // 25 MHz bench clock
  initial begin
    sys_clk = 1'b0;
    forever #20 sys_clk = ~sys_clk;
  end

  // reset held for the first 16 rising edges
  initial begin
    reset = 1'b1;
    repeat (16) @(posedge sys_clk);
    reset <= 1'b0;
  end

endmodule

/* bench/pin_bank_tb.sv */
// directed testbench for the pin bank and simulation top of the tb.f file list
`timescale 1ns/1ps

module pin_bank_tb;
  import bus_pkg::*;
  import pin_pkg::*;

  localparam int PERIOD  = 256;
  // shape follow length of one position per two cycles plus a few
  localparam int OBS_CYC = 2 * PERIOD + 8;
  // shapes, four duty periods, end of run, stop wait, ~100 transfers, margin
  localparam int WATCHDOG_CYC = 16 + 2 * OBS_CYC + 8 * PERIOD + 100 * 3 + 1000;
  localparam apb_rsp_t ERR_RSP = '{prdata: '0, pready: 1'b1, pslverr: 1'b1};

  logic        sys_clk;
  logic        reset;
  apb_req_t    req;
  apb_rsp_t    rsp;
  pin_out_t    pins [NUM_PINS];
  logic [15:0] lfsr_state;
  int          checks;
  int          errors;

  bench_clock clk_gen (.sys_clk(sys_clk), .reset(reset));

  pin_bank_top uut (
    .sys_clk (sys_clk),
    .reset   (reset),
    .req     (req),
    .rsp     (rsp),
    .pins    (pins)
  );

  // galois lfsr with taps 16 14 13 11 stepped once per bit
  function automatic logic [15:0] take_bits(input int n);
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[14:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hB400) : (lfsr_state >> 1);
    end
    return v;
  endfunction

  // level and pin for position p from the waveform rules
  function automatic pin_out_t expect_out(input wave_t w, input int p, input int duty);
    pin_out_t o;
    int       pm;
    pm = p % 256;
    o  = '0;
    case (w)
      WAVE_SQUARE: o.level = (pm < 128) ? 8'd255 : 8'd0;
      WAVE_SAW:    o.level = 8'(pm);
      WAVE_TRI:    o.level = (pm < 128) ? 8'(2 * pm) : 8'(2 * (255 - pm));
      WAVE_PWM:    o.level = (pm < duty) ? 8'd255 : 8'd0;
      default:     o.level = 8'd0;
    endcase
    o.pin = (w == WAVE_PWM) ? (pm < duty) : o.level[7];
    return o;
  endfunction

  function automatic pin_status_t status_val(input logic run, input int tick);
    return '{running: run, cur_tick: 16'(tick)};
  endfunction

  function automatic apb_rsp_t ok_rsp(input logic [15:0] data);
    return '{prdata: data, pready: 1'b1, pslverr: 1'b0};
  endfunction

  // peek at a channel's run state inside the DUT
  function automatic pin_status_t status_of(input int ch);
    return uut.status[ch];
  endfunction

  task automatic check_rsp(input apb_rsp_t got, input apb_rsp_t exp, input string msg);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t: %s: data %h rdy %b err %b, expected data %h rdy %b err %b", $time,
               msg, got.prdata, got.pready, got.pslverr, exp.prdata, exp.pready, exp.pslverr);
    end
  endtask

  task automatic check_out(input pin_out_t got, input pin_out_t exp, input string msg);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t: %s: level %h pin %b, expected level %h pin %b", $time, msg,
               got.level, got.pin, exp.level, exp.pin);
    end
  endtask

  task automatic check_status(input pin_status_t got, input pin_status_t exp,
                              input string msg);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t: %s: running %b cur_tick %0d, expected running %b cur_tick %0d",
               $time, msg, got.running, got.cur_tick, exp.running, exp.cur_tick);
    end
  endtask

  task automatic check_count(input int got, input int exp, input string msg);
    checks++;
    if (got != exp) begin
      errors++;
      $display("ERR %0t: %s: got %0d, expected %0d", $time, msg, got, exp);
    end
  endtask

  // one zero wait transfer with the response sampled mid access cycle
  task automatic bus_transfer(input int ch, input reg_idx_t idx, input logic wr,
                              input logic [15:0] data, output apb_rsp_t got);
    @(posedge sys_clk);
    req <= '{paddr: 8'((ch << CHAN_LSB) | (int'(idx) << IDX_LSB)), psel: 1'b1,
             penable: 1'b0, pwrite: wr, pwdata: data};
    @(posedge sys_clk);
    req.penable <= 1'b1;
    @(negedge sys_clk);
    got = rsp;
    // write lands on this edge
    @(posedge sys_clk);
    req <= '0;
  endtask

  task automatic apb_write(input int ch, input reg_idx_t idx, input logic [15:0] data,
                           output apb_rsp_t got);
    bus_transfer(ch, idx, 1'b1, data, got);
  endtask

  task automatic apb_read(input int ch, input reg_idx_t idx, output apb_rsp_t got);
    bus_transfer(ch, idx, 1'b0, 16'h0, got);
  endtask

  task automatic write_good(input int ch, input reg_idx_t idx, input logic [15:0] data);
    apb_rsp_t got;
    apb_write(ch, idx, data, got);
    check_rsp(got, ok_rsp(16'h0), "write response");
  endtask

  task automatic read_expect(input int ch, input reg_idx_t idx, input logic [15:0] exp,
                             input string msg);
    apb_rsp_t got;
    apb_read(ch, idx, got);
    check_rsp(got, ok_rsp(exp), msg);
  endtask

  // running rises and cur_tick clears two edges after the ctrl write
  task automatic wait_loaded(input int ch);
    repeat (2) @(posedge sys_clk);
    @(negedge sys_clk);
    check_status(status_of(ch), status_val(1'b1, 0), "status after start");
  endtask

  task automatic start_channel(input int ch, input wave_t w, input logic [15:0] div,
                               input logic [7:0] phase, input logic [15:0] ticks);
    write_good(ch, REG_STEP_DIV, div);
    write_good(ch, REG_PHASE, 16'(phase));
    write_good(ch, REG_TICKS, ticks);
    write_good(ch, REG_CTRL, 16'(w));
    wait_loaded(ch);
  endtask

  task automatic test_registers();
    logic [15:0] f [NUM_PINS][4];
    apb_rsp_t    got;
    // step_div, phase, duty, ticks for each channel
    for (int c = 0; c < NUM_PINS; c++) begin
      f[c][0] = take_bits(16);
      f[c][1] = take_bits(8);
      f[c][2] = take_bits(8);
      f[c][3] = take_bits(16);
      for (int j = 0; j < 4; j++) begin
        write_good(c, reg_idx_t'(j + 1), f[c][j]);
        read_expect(c, reg_idx_t'(j + 1), f[c][j], "readback");
      end
    end
    apb_write(4, REG_PHASE, 16'h0055, got);
    check_rsp(got, ERR_RSP, "write to channel 4");
    apb_read(4, REG_PHASE, got);
    check_rsp(got, ERR_RSP, "read from channel 4");
    apb_write(0, REG_UNDEF, 16'h00ff, got);
    check_rsp(got, ERR_RSP, "write to index 7");
    apb_write(1, REG_CUR_TICK, 16'h1234, got);
    check_rsp(got, ERR_RSP, "write to cur_tick");
    apb_write(2, REG_CTRL, 16'h0006, got);
    check_rsp(got, ERR_RSP, "illegal wave code");
    read_expect(1, REG_CUR_TICK, 16'h0, "cur_tick after rejected write");
    read_expect(2, REG_CTRL, 16'h0, "ctrl after rejected write");
    read_expect(2, REG_STATUS, 16'h0, "status after rejected write");
    // nothing moved
    for (int c = 0; c < NUM_PINS; c++) begin
      for (int j = 0; j < 4; j++) begin
        read_expect(c, reg_idx_t'(j + 1), f[c][j], "readback after errors");
      end
    end
  endtask

  // every cycle checked while the position moves every second cycle
  task automatic follow_shape(input int ch, input wave_t w, input logic [7:0] phase);
    start_channel(ch, w, 16'd2, phase, 16'd0);
    for (int k = 0; k < OBS_CYC; k++) begin
      check_out(pins[ch], expect_out(w, int'(phase) + k / 2, 0), "shape sequence");
      @(posedge sys_clk);
      @(negedge sys_clk);
    end
  endtask

  task automatic test_shapes();
    logic [7:0] phase;
    phase = 8'(take_bits(8));
    follow_shape(0, WAVE_SAW, phase);
    follow_shape(1, WAVE_TRI, phase);
    write_good(0, REG_CTRL, 16'(WAVE_OFF));
    write_good(1, REG_CTRL, 16'(WAVE_OFF));
  endtask

  // pin-high steps over one period where a step is a change of the companion sawtooth
  task automatic count_high(input int ch, input int comp, input wave_t w,
                            input logic [7:0] phase, input int duty, input int exp,
                            input string msg);
    int         steps;
    int         high;
    int         guard;
    logic [7:0] prev;
    steps = 0;
    high  = 0;
    guard = 0;
    prev  = pins[comp].level;
    while (steps < PERIOD && guard < 4 * PERIOD) begin
      @(posedge sys_clk);
      @(negedge sys_clk);
      guard++;
      if (pins[comp].level != prev) begin
        steps++;
        high += int'(pins[ch].pin);
        prev = pins[comp].level;
        // both step every cycle so ch sits that many steps past its phase
        check_out(pins[ch], expect_out(w, int'(phase) + steps, duty), "output per step");
      end
    end
    if (steps < PERIOD) begin
      errors++;
      $display("companion channel %0d stopped stepping after %0d steps", comp, steps);
    end
    check_count(high, exp, msg);
  endtask

  task automatic test_duty();
    logic [7:0] duty [3];
    logic [7:0] phase;
    duty[0] = 8'd0;
    duty[1] = 8'd255;
    duty[2] = 8'(take_bits(8));
    phase   = 8'(take_bits(8));
    start_channel(2, WAVE_SAW, 16'd1, 8'd0, 16'd0);
    start_channel(3, WAVE_SQUARE, 16'd1, phase, 16'd0);
    count_high(3, 2, WAVE_SQUARE, phase, 0, 128, "square high steps");
    for (int i = 0; i < 3; i++) begin
      write_good(3, REG_DUTY, 16'(duty[i]));
      write_good(3, REG_CTRL, 16'(WAVE_PWM));
      wait_loaded(3);
      count_high(3, 2, WAVE_PWM, phase, int'(duty[i]), int'(duty[i]), "pwm high steps");
    end
  endtask

  task automatic test_run_end();
    logic [7:0]  phase;
    int          n;
    int          expect_n;
    pin_status_t st;
    phase    = 8'(take_bits(8));
    // first partial period then one full one
    expect_n = (256 - int'(phase)) + 256 * (2 - 1);
    start_channel(0, WAVE_SAW, 16'd1, phase, 16'd2);
    n  = 0;
    st = status_of(0);
    while (st.running && n < expect_n + 16) begin
      @(posedge sys_clk);
      @(negedge sys_clk);
      n++;
      st = status_of(0);
    end
    check_count(n, expect_n, "cycles until running clears");
    check_status(st, status_val(1'b0, 2), "status at end of run");
    check_out(pins[0], '0, "output at end of run");
    read_expect(0, REG_CUR_TICK, 16'd2, "cur_tick at end of run");
  endtask

  // channel 0 ended while 2 and 3 keep free running
  task automatic check_bystanders();
    check_status(status_of(0), status_val(1'b0, 2), "channel 0 disturbed");
    check_out(pins[0], '0, "channel 0 output disturbed");
    read_expect(2, REG_STATUS, 16'd1, "channel 2 disturbed");
    read_expect(3, REG_STATUS, 16'd1, "channel 3 disturbed");
  endtask

  task automatic test_stop_restart();
    logic [7:0]  phase;
    pin_status_t st;
    int          guard;
    phase = 8'(take_bits(8));
    start_channel(1, WAVE_TRI, 16'd1, phase, 16'd0);
    // stop early in the second period
    guard = 0;
    st    = status_of(1);
    while (st.cur_tick == 0 && guard < 2 * PERIOD) begin
      @(posedge sys_clk);
      @(negedge sys_clk);
      guard++;
      st = status_of(1);
    end
    write_good(1, REG_CTRL, 16'(WAVE_OFF));
    repeat (2) @(posedge sys_clk);
    @(negedge sys_clk);
    check_status(status_of(1), status_val(1'b0, 1), "status after stop");
    check_out(pins[1], '0, "output after stop");
    read_expect(1, REG_CUR_TICK, 16'd1, "cur_tick kept after stop");
    check_bystanders();
    phase = 8'(take_bits(8));
    write_good(1, REG_PHASE, 16'(phase));
    write_good(1, REG_CTRL, 16'(WAVE_TRI));
    wait_loaded(1);
    check_out(pins[1], expect_out(WAVE_TRI, int'(phase), 0), "output after restart");
    check_bystanders();
  endtask

  initial begin
    req        = '0;
    lfsr_state = 16'd21;
    checks     = 0;
    errors     = 0;
    @(negedge reset);
    test_registers();
    test_shapes();
    test_duty();
    test_run_end();
    test_stop_restart();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  // hard stop if a test hangs
  initial begin
    repeat (WATCHDOG_CYC) @(posedge sys_clk);
    $display("tests did not finish within %0d cycles", WATCHDOG_CYC);
    $display("checks %0d, errors %0d", checks, errors);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

/* tb.f */
logic/bus_pkg.sv
logic/pin_pkg.sv
logic/apb_regfile.sv
logic/channel_fsm.sv
logic/step_timer.sv
logic/wave_shaper.sv
logic/pin_bank_top.sv
bench/bench_clock.sv
bench/pin_bank_tb.sv
